/* filelist.f */
source/fedp_pkg.sv
source/fedp_prod_if.sv
source/fedp_classifier.sv
source/fedp_mul_lanes.sv
source/fedp_accum.sv
source/fedp_step_counter.sv
source/fedp_ctrl_fsm.sv
source/fedp_top.sv
bench/fedp_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the FEDP testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module fedp_tb \
    -f filelist.f -o fedp_sim &&
{ out=$(./obj_dir/fedp_sim); printf '%s\n' "$out"; } &&
printf '%s\n' "$out" | grep -qx 'sim passed' ||
{ echo "FEDP simulation did not pass"; exit 1; }

/* bench/fedp_tb.sv */
/*
 * FEDP testbench
 * Table-driven dot products in FP16 and BF16 through the
 * req/ack handshake, with result, flag and timing checks.
 */

`timescale 1ns/10ps

module fedp_tb;
    import fedp_pkg::*;

    localparam int NUM_VEC    = 15;
    localparam int MAX_CYCLES = NUM_VEC * 12 + 50;

    logic                     clk;
    logic                     rst_n;
    logic                     req;
    logic [1:0]               fmt;
    logic [K-1:0][15:0]       a_vec;
    logic [K-1:0][15:0]       b_vec;
    logic                     ack;
    logic signed [ACC_W-1:0]  result;
    logic                     res_nan;
    logic                     res_inf;
    logic                     res_ovf;

    // Stimulus and expected values, flags are {nan, inf, ovf}
    string                    t_name  [NUM_VEC];
    logic [1:0]               t_fmt   [NUM_VEC];
    logic [K-1:0][15:0]       t_a     [NUM_VEC];
    logic [K-1:0][15:0]       t_b     [NUM_VEC];
    logic [ACC_W-1:0]         t_res   [NUM_VEC];
    logic [2:0]               t_flags [NUM_VEC];

    int n_vec        = 0;
    int errors       = 0;
    int failed_tests = 0;
    int cycles       = 0;

    fedp_top dut0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .fmt     (fmt),
        .a_vec   (a_vec),
        .b_vec   (b_vec),
        .ack     (ack),
        .result  (result),
        .res_nan (res_nan),
        .res_inf (res_inf),
        .res_ovf (res_ovf)
    );

    always #50 clk = ~clk;

    // Watchdog sized from the table length
    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("sim failed");
            $finish;
        end
    end

    // Element 0 sits in the low 16 bits
    function automatic logic [K*16-1:0] quad(input logic [15:0] e0, input logic [15:0] e1,
                                              input logic [15:0] e2, input logic [15:0] e3);
        return {e3, e2, e1, e0};
    endfunction

    task automatic add_vec(input string name, input logic [1:0] f, input logic [K*16-1:0] a,
                           input logic [K*16-1:0] b, input logic [ACC_W-1:0] res,
                           input logic [2:0] flags);
        t_name[n_vec]  = name;
        t_fmt[n_vec]   = f;
        t_a[n_vec]     = a;
        t_b[n_vec]     = b;
        t_res[n_vec]   = res;
        t_flags[n_vec] = flags;
        n_vec++;
    endtask

    // --------------------------------------------------
    // Vector table, values scaled by 2^24
    // --------------------------------------------------
    task automatic load_table();
        add_vec("fp16 mixed signs", FMT_FP16, quad('h3c00, 'h4000, 'h4200, 'h3800),
                quad('h4000, 'hbc00, 'h4400, 'h3e00), 48'h0000_0cc0_0000, 3'b000);
        add_vec("fp16 cancel to zero", FMT_FP16, quad('h3c00, 'h3c00, 'h4000, 'h4000),
                quad('h3c00, 'hbc00, 'h4000, 'hc000), 48'h0000_0000_0000, 3'b000);
        add_vec("fp16 negative sum", FMT_FP16, quad('hbc00, 'h3800, 'h0000, 'h0000),
                quad('h4200, 'h3800, 'h3c00, 'h3c00), 48'hffff_fd40_0000, 3'b000);
        add_vec("bf16 mixed signs", FMT_BF16, quad('h3f80, 'h4000, 'h4040, 'h3f00),
                quad('h4000, 'hbf80, 'h4080, 'h3fc0), 48'h0000_0cc0_0000, 3'b000);
        add_vec("bf16 negative sum", FMT_BF16, quad('hbf80, 'h3f00, 'h0000, 'h0000),
                quad('h4040, 'h3f00, 'h3f80, 'h3f80), 48'hffff_fd40_0000, 3'b000);
        // Lanes 2 and 3 fall below 2^-24 and truncate toward zero
        add_vec("fp16 subnormals", FMT_FP16, quad('h0001, 'h0200, 'h0003, 'h8002),
                quad('h3c00, 'h4200, 'h3400, 'h3400), 48'h0000_0000_0601, 3'b000);
        add_vec("bf16 subnormal and zero", FMT_BF16, quad('h0080, 'h0040, 'h8000, 'h0001),
                quad('h7f00, 'h7f00, 'h3f80, 'h3f80), 48'h0000_0300_0000, 3'b000);
        add_vec("fp16 nan operand", FMT_FP16, quad('h7e00, 'h3c00, 'h3c00, 'h3c00),
                quad('h3c00, 'h3c00, 'h3c00, 'h3c00), 48'h0, 3'b100);
        add_vec("fp16 inf times zero", FMT_FP16, quad('h7c00, 'h3c00, 'h0000, 'h0000),
                quad('h0000, 'h3c00, 'h0000, 'h0000), 48'h0, 3'b100);
        add_vec("fp16 inf both signs", FMT_FP16, quad('h7c00, 'h0000, 'h0000, 'hfc00),
                quad('h3c00, 'h0000, 'h0000, 'h3c00), 48'h0, 3'b100);
        add_vec("fp16 inf one sign", FMT_FP16, quad('h7c00, 'h3c00, 'hfc00, 'h3c00),
                quad('h3c00, 'h4000, 'hfc00, 'h3c00), 48'h0, 3'b010);
        add_vec("bf16 nan operand", FMT_BF16, quad('h3f80, 'h3f80, 'h7fc0, 'h3f80),
                quad('h3f80, 'h3f80, 'h3f80, 'h3f80), 48'h0, 3'b100);
        add_vec("bf16 neg inf", FMT_BF16, quad('hff80, 'h3f80, 'h3f80, 'h3f80),
                quad('h3f80, 'h3f80, 'h3f80, 'h3f80), 48'h0, 3'b010);
        // 2^12 squared leaves the accumulator entirely
        add_vec("fp16 lane overflow", FMT_FP16, quad('h6c00, 'h0000, 'h0000, 'h0000),
                quad('h6c00, 'h0000, 'h0000, 'h0000), 48'h0, 3'b001);
        // Four times 2^22 wraps through the sign on the first beat
        add_vec("fp16 sum overflow", FMT_FP16, quad('h6800, 'h6800, 'h6800, 'h6800),
                quad('h6800, 'h6800, 'h6800, 'h6800), 48'h0, 3'b001);
    endtask

    // Called on a falling edge, returns on the falling edge after ack drops
    task automatic run_vec(input int idx);
        int               wait_n;
        int               errs_before;
        logic [ACC_W-1:0] held;
        errs_before = errors;
        fmt   = t_fmt[idx];
        a_vec = t_a[idx];
        b_vec = t_b[idx];
        req   = 1'b1;
        wait_n = 0;
        do begin
            @(negedge clk);
            wait_n++;
        end while (!ack && wait_n < 10);
        // First negedge comes half a cycle after req is sampled
        if (!ack) begin
            $display("ack never arrived for test %0d", idx);
            errors++;
        end else if (wait_n - 1 != 4) begin
            $display("ack came %0d cycles after req was sampled, not 4", wait_n - 1);
            errors++;
        end
        if (result !== t_res[idx]) begin
            $display("MISMATCH t=%0t result got %h expected %h", $time, result, t_res[idx]);
            errors++;
        end
        if (res_nan !== t_flags[idx][2]) begin
            $display("MISMATCH t=%0t res_nan got %b expected %b", $time, res_nan,
                     t_flags[idx][2]);
            errors++;
        end
        if (res_inf !== t_flags[idx][1]) begin
            $display("MISMATCH t=%0t res_inf got %b expected %b", $time, res_inf,
                     t_flags[idx][1]);
            errors++;
        end
        if (res_ovf !== t_flags[idx][0]) begin
            $display("MISMATCH t=%0t res_ovf got %b expected %b", $time, res_ovf,
                     t_flags[idx][0]);
            errors++;
        end
        // Result and ack must hold while req stays up
        held = result;
        repeat (2) begin
            @(negedge clk);
            if (!ack) begin
                $display("ack dropped while req was still high");
                errors++;
            end
            if (result !== held) begin
                $display("MISMATCH t=%0t result got %h expected %h", $time, result, held);
                errors++;
            end
        end
        req = 1'b0;
        wait_n = 0;
        do begin
            @(negedge clk);
            wait_n++;
        end while (ack && wait_n < 10);
        if (ack) begin
            $display("ack stayed high after req was dropped");
            errors++;
        end else if (wait_n != 1) begin
            $display("ack fell %0d cycles after req dropped, not 1", wait_n);
            errors++;
        end
        if (errors != errs_before)
            failed_tests++;
        $display("test %0d %s: %s", idx, t_name[idx], (errors == errs_before) ? "ok" : "FAILED");
    endtask

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        req   = 1'b0;
        fmt   = FMT_FP16;
        a_vec = '0;
        b_vec = '0;
        load_table();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Outputs straight out of reset
        if (ack !== 1'b0 || result !== '0 || res_nan !== 1'b0 || res_inf !== 1'b0
            || res_ovf !== 1'b0) begin
            $display("outputs not cleared after reset");
            errors++;
            failed_tests++;
        end
        $display("test reset: %s", (errors == 0) ? "ok" : "FAILED");

        // Back to back, each req goes up on the edge ack is seen low
        for (int i = 0; i < n_vec; i++)
            run_vec(i);

        $display("%0d tests run, %0d failed, %0d errors", n_vec + 1, failed_tests, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

/* source/fedp_top.sv */
/*
 * FEDP top
 * Four-element FP16/BF16 dot product with a req/ack
 * handshake and a signed fixed-point result.
 */

`timescale 1ns/10ps

module fedp_top (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   req,
    input  logic [1:0]                             fmt,
    input  logic [fedp_pkg::K-1:0][15:0]           a_vec,
    input  logic [fedp_pkg::K-1:0][15:0]           b_vec,
    output logic                                   ack,
    output logic signed [fedp_pkg::ACC_W-1:0]      result,
    output logic                                   res_nan,
    output logic                                   res_inf,
    output logic                                   res_ovf
);
    import fedp_pkg::*;

    logic                         start;
    logic                         step;
    logic                         finish;
    logic                         last;
    logic [STEP_W-1:0]            count;
    logic [1:0]                   fmt_q;
    logic [K-1:0][15:0]           a_q;
    logic [K-1:0][15:0]           b_q;
    logic [LANES-1:0][15:0]       a_pair;
    logic [LANES-1:0][15:0]       b_pair;

    fedp_prod_if prod_bus ();

    // Operand capture
    always_ff @(posedge clk) begin
        if (start) begin
            fmt_q <= fmt;
            a_q   <= a_vec;
            b_q   <= b_vec;
        end
    end

    // Pair slice for the current step
    for (genvar l = 0; l < LANES; l++) begin : g_sel
        assign a_pair[l] = a_q[int'(count) * LANES + l];
        assign b_pair[l] = b_q[int'(count) * LANES + l];
    end

    fedp_ctrl_fsm u_ctrl (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (req),
        .last   (last),
        .start  (start),
        .step   (step),
        .finish (finish),
        .ack    (ack)
    );

    fedp_step_counter u_cnt (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .step  (step),
        .count (count),
        .last  (last)
    );

    fedp_mul_lanes u_mul (
        .clk       (clk),
        .rst_n     (rst_n),
        .step      (step),
        .last_step (last),
        .fmt       (fmt_q),
        .a_pair    (a_pair),
        .b_pair    (b_pair),
        .prod      (prod_bus.producer)
    );

    fedp_accum u_acc (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .prod    (prod_bus.consumer),
        .result  (result),
        .res_nan (res_nan),
        .res_inf (res_inf),
        .res_ovf (res_ovf)
    );

    // Controller drain cycle lines up with the final product beat
    a_drain_on_last: assert property (@(posedge clk) disable iff (!rst_n)
        finish |-> prod_bus.valid && prod_bus.last);

endmodule

/* source/fedp_ctrl_fsm.sv */
/*
 * FEDP controller
 * Four-phase req/ack handshake, sequences capture, the
 * multiply steps, the drain beat and the result hold.
 */

`timescale 1ns/10ps

module fedp_ctrl_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic req,
    input  logic last,
    output logic start,
    output logic step,
    output logic finish,
    output logic ack
);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN,
        DONE
    } state_t;

    state_t state_q;
    state_t state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (req) state_d = RUN;
            RUN:     if (last) state_d = DRAIN;
            // Last beat enters the accumulator here
            DRAIN:   state_d = DONE;
            DONE:    if (!req) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
            ack     <= 1'b0;
        end else begin
            state_q <= state_d;
            // Held while req stays up, drops the edge req is seen low
            ack     <= (state_q == DONE) && req;
        end
    end

    assign start  = (state_q == IDLE) && req;
    assign step   = (state_q == RUN);
    assign finish = (state_q == DRAIN);

    // Requester drops req only once ack is up
    a_req_until_ack: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(req) |-> ack);

endmodule

/* source/fedp_step_counter.sv */
/*
 * FEDP step counter
 * Tracks which operand pair slice is being multiplied and
 * flags the final step of a request.
 */

`timescale 1ns/10ps

module fedp_step_counter (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start,
    input  logic                         step,
    output logic [fedp_pkg::STEP_W-1:0]  count,
    output logic                         last
);
    import fedp_pkg::*;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            count <= '0;
        else if (start)
            count <= '0;
        else if (step)
            count <= last ? '0 : count + 1'b1;
    end

    assign last = (count == STEP_W'(STEPS - 1));

endmodule

/* source/fedp_accum.sv */
/*
 * FEDP accumulator
 * Aligns each lane product onto the fixed-point grid, adds
 * the signed terms and keeps sticky NaN, inf and overflow.
 */

`timescale 1ns/10ps

module fedp_accum (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                start,
    fedp_prod_if.consumer                       prod,
    output logic signed [fedp_pkg::ACC_W-1:0]   result,
    output logic                                res_nan,
    output logic                                res_inf,
    output logic                                res_ovf
);
    import fedp_pkg::*;

    localparam int WIDE_W = ACC_W + PROD_W;

    logic signed [ACC_W-1:0]   acc_q;
    logic                      nan_q;
    logic                      pinf_q;
    logic                      ninf_q;
    logic                      ovf_q;
    logic signed [ACC_W-1:0]   term [LANES];
    logic [LANES-1:0]          lane_ovf;
    logic signed [ACC_W+1:0]   sum_ext;
    logic                      sum_ovf;

    // --------------------------------------------------
    // Alignment per lane
    // --------------------------------------------------
    always_comb begin
        logic signed [EXP_W-1:0] sh;
        logic [WIDE_W-1:0]       wide;
        for (int l = 0; l < LANES; l++) begin
            sh          = $signed(prod.exp[l]);
            wide        = '0;
            lane_ovf[l] = 1'b0;
            if (sh < 0) begin
                // Bits below 2^-FRAC_W drop off
                if (sh > -PROD_W)
                    wide = WIDE_W'(prod.sig[l]) >> (-sh);
            end else if (sh < ACC_W) begin
                wide = WIDE_W'(prod.sig[l]) << sh;
            end else begin
                lane_ovf[l] = (prod.sig[l] != '0);
            end
            // Magnitude must fit below the sign bit
            if (wide[WIDE_W-1:ACC_W-1] != '0)
                lane_ovf[l] = 1'b1;
            // Exceptional lanes contribute nothing numeric
            if (prod.nan[l] || prod.inf[l]) begin
                wide        = '0;
                lane_ovf[l] = 1'b0;
            end
            term[l] = prod.sign[l] ? -$signed(wide[ACC_W-1:0]) : $signed(wide[ACC_W-1:0]);
        end
    end

    always_comb begin
        sum_ext = acc_q;
        for (int l = 0; l < LANES; l++)
            sum_ext = sum_ext + term[l];
    end

    // Two guard bits must match the sign
    assign sum_ovf = (sum_ext[ACC_W+1:ACC_W-1] != 3'b000) && (sum_ext[ACC_W+1:ACC_W-1] != 3'b111);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_q  <= '0;
            nan_q  <= 1'b0;
            pinf_q <= 1'b0;
            ninf_q <= 1'b0;
            ovf_q  <= 1'b0;
        end else if (start) begin
            acc_q  <= '0;
            nan_q  <= 1'b0;
            pinf_q <= 1'b0;
            ninf_q <= 1'b0;
            ovf_q  <= 1'b0;
        end else if (prod.valid) begin
            acc_q  <= sum_ext[ACC_W-1:0];
            nan_q  <= nan_q | (|prod.nan);
            pinf_q <= pinf_q | (|(prod.inf & ~prod.sign));
            ninf_q <= ninf_q | (|(prod.inf & prod.sign));
            ovf_q  <= ovf_q | (|lane_ovf) | sum_ovf;
        end
    end

    // +inf and -inf together is invalid
    assign res_nan = nan_q | (pinf_q & ninf_q);
    assign res_inf = ~res_nan & (pinf_q | ninf_q);
    assign res_ovf = ovf_q;
    assign result  = (res_nan || res_inf) ? '0 : acc_q;

    // Clear and a beat never collide
    a_no_beat_on_start: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> !prod.valid);

    // The final beat of a request is followed by a gap
    a_gap_after_last: assert property (@(posedge clk) disable iff (!rst_n)
        prod.valid && prod.last |=> !prod.valid);

endmodule

/* source/fedp_mul_lanes.sv */
/*
 * FEDP multiplier lanes
 * Multiplies LANES operand pairs per step and forms sign,
 * biased exponent sum, significand product and exceptions.
 * The beat is registered onto the product interface.
 */

`timescale 1ns/10ps

module fedp_mul_lanes (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                step,
    input  logic                                last_step,
    input  logic [1:0]                          fmt,
    input  logic [fedp_pkg::LANES-1:0][15:0]    a_pair,
    input  logic [fedp_pkg::LANES-1:0][15:0]    b_pair,
    fedp_prod_if.producer                       prod
);
    import fedp_pkg::*;

    logic                         is_bf16;
    logic [EXP_W-1:0]             bias;
    logic [LANES-1:0]             sign_c;
    logic [LANES-1:0]             nan_c;
    logic [LANES-1:0]             inf_c;
    logic [LANES-1:0][EXP_W-1:0]  exp_c;
    logic [LANES-1:0][PROD_W-1:0] sig_c;

    // Effective exponent, subnormals run at exponent 1
    function automatic logic [7:0] eff_exp(input logic [15:0] v, input fedp_class_t c,
                                           input logic bf16);
        if (c.is_sub)
            return 8'd1;
        return bf16 ? v[14:7] : {3'b000, v[14:10]};
    endfunction

    // Significand with hidden bit, zero forces it clear
    function automatic logic [MAN_W-1:0] eff_man(input logic [15:0] v, input fedp_class_t c,
                                                 input logic bf16);
        if (c.is_zero)
            return '0;
        return bf16 ? {3'b000, ~c.is_sub, v[6:0]} : {~c.is_sub, v[9:0]};
    endfunction

    assign is_bf16 = (fmt == FMT_BF16);
    assign bias    = is_bf16 ? EXP_W'(PROD_BIAS_BF16) : EXP_W'(PROD_BIAS_FP16);

    for (genvar l = 0; l < LANES; l++) begin : g_lane
        fedp_class_t cls_a;
        fedp_class_t cls_b;
        logic        inf_zero;

        fedp_classifier u_cls_a (.val(a_pair[l]), .fmt(fmt), .cls(cls_a));
        fedp_classifier u_cls_b (.val(b_pair[l]), .fmt(fmt), .cls(cls_b));

        assign sign_c[l] = cls_a.sign ^ cls_b.sign;
        assign exp_c[l]  = {2'b00, eff_exp(a_pair[l], cls_a, is_bf16)}
                         + {2'b00, eff_exp(b_pair[l], cls_b, is_bf16)} + bias;
        assign sig_c[l]  = eff_man(a_pair[l], cls_a, is_bf16)
                         * eff_man(b_pair[l], cls_b, is_bf16);

        // inf * 0 is invalid
        assign inf_zero = (cls_a.is_inf & cls_b.is_zero) | (cls_a.is_zero & cls_b.is_inf);
        assign nan_c[l] = cls_a.is_nan | cls_b.is_nan | inf_zero;
        assign inf_c[l] = (cls_a.is_inf | cls_b.is_inf) & ~nan_c[l];
    end

    // --------------------------------------------------
    // Beat register, lands in the accumulator next cycle
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prod.valid <= 1'b0;
            prod.last  <= 1'b0;
        end else begin
            prod.valid <= step;
            prod.last  <= step & last_step;
        end
    end

    always_ff @(posedge clk) begin
        if (step) begin
            prod.sign <= sign_c;
            prod.exp  <= exp_c;
            prod.sig  <= sig_c;
            prod.nan  <= nan_c;
            prod.inf  <= inf_c;
        end
    end

    // Operand register in the top must hold a legal format while stepping
    a_fmt_legal: assert property (@(posedge clk) disable iff (!rst_n)
        step |-> (fmt == FMT_FP16 || fmt == FMT_BF16));

endmodule

/* source/fedp_classifier.sv */
/*
 * FEDP operand classifier
 * Splits a 16-bit FP16 or BF16 value into its fields and
 * reports zero, subnormal, infinity, NaN and sign.
 */

`timescale 1ns/10ps

module fedp_classifier (
    input  logic                  [15:0] val,
    input  logic                  [1:0]  fmt,
    output fedp_pkg::fedp_class_t        cls
);
    import fedp_pkg::*;

    logic exp_zero;
    logic exp_ones;
    logic man_zero;

    // Field split per format
    always_comb begin
        if (fmt == FMT_BF16) begin
            exp_zero = (val[14:7] == 8'h00);
            exp_ones = (val[14:7] == 8'hff);
            man_zero = (val[6:0] == 7'h00);
        end else begin
            exp_zero = (val[14:10] == 5'h00);
            exp_ones = (val[14:10] == 5'h1f);
            man_zero = (val[9:0] == 10'h000);
        end
    end

    assign cls.is_zero = exp_zero & man_zero;
    assign cls.is_sub  = exp_zero & ~man_zero;
    assign cls.is_inf  = exp_ones & man_zero;
    assign cls.is_nan  = exp_ones & ~man_zero;
    assign cls.sign    = val[15];

endmodule

/* source/fedp_prod_if.sv */
/*
 * FEDP product beat
 * One cycle of products, ready for alignment, from the
 * multiplier lanes to the accumulator. No back-pressure.
 */

`timescale 1ns/10ps

interface fedp_prod_if;
    import fedp_pkg::*;

    logic                         valid;
    logic                         last;
    logic [LANES-1:0]             sign;
    logic [LANES-1:0][EXP_W-1:0]  exp;
    logic [LANES-1:0][PROD_W-1:0] sig;
    logic [LANES-1:0]             nan;
    logic [LANES-1:0]             inf;

    modport producer (output valid, last, sign, exp, sig, nan, inf);

    modport consumer (input valid, last, sign, exp, sig, nan, inf);

endinterface

/* source/fedp_pkg.sv */
/*
 * FEDP shared definitions
 * Format codes, datapath widths, product bias constants
 * and the per-operand class record.
 */

package fedp_pkg;

    // Operand format codes, codes 2 and 3 are illegal
    localparam logic [1:0] FMT_FP16 = 2'd0;
    localparam logic [1:0] FMT_BF16 = 2'd1;

    // Vector shape
    localparam int K      = 4;
    localparam int LANES  = 2;
    localparam int STEPS  = K / LANES;
    localparam int STEP_W = (STEPS > 1) ? $clog2(STEPS) : 1;

    // --------------------------------------------------
    // Datapath widths
    // --------------------------------------------------
    localparam int EXP_W  = 10;
    localparam int MAN_W  = 11;
    localparam int PROD_W = 2 * MAN_W;
    localparam int ACC_W  = 48;
    localparam int FRAC_W = 24;

    // IEEE exponent biases of the two inputs
    localparam int FP16_EXP_BIAS = 15;
    localparam int BF16_EXP_BIAS = 127;

    // Fraction bits in the raw significand product
    localparam int FP16_PROD_FRAC = 20;
    localparam int BF16_PROD_FRAC = 14;

    // ea + eb + bias gives the left shift onto the accumulator point.
    // Negative results mean a right shift with truncation.
    localparam int PROD_BIAS_FP16 = FRAC_W - FP16_PROD_FRAC - 2 * FP16_EXP_BIAS;
    localparam int PROD_BIAS_BF16 = FRAC_W - BF16_PROD_FRAC - 2 * BF16_EXP_BIAS;

    // Operand class record
    typedef struct packed {
        logic is_zero;
        logic is_sub;
        logic is_inf;
        logic is_nan;
        logic sign;
    } fedp_class_t;

endpackage
